// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal -f cpu_top.f --top-module tb_cpu_top \
		-Mdir obj_dir -o tb_cpu_top
	./obj_dir/tb_cpu_top | tee sim.log
	@grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cpu_top.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/forward_unit.sv
rtl/regfile.sv
rtl/mem_arbiter.sv
rtl/unified_mem.sv
rtl/pipe_core.sv
rtl/cpu_top.sv
tests/tb_cpu_top.sv

// ==== rtl/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and register file geometry
`define CPU_XLEN      32   // word width, data and instructions
`define CPU_REGS      32   // architectural registers, r0 hardwired to zero

// unified memory, word addressed
`define CPU_MEM_WORDS 1024
`define CPU_ADDR_W    10   // log2 of CPU_MEM_WORDS

`endif

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_top (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   load_valid,  // one word per strobe
   input  wire logic [`CPU_ADDR_W-1:0] load_addr,
   input  wire logic [`CPU_XLEN-1:0]   load_data,
   output logic                        wb_valid,
   output pipe_pkg::wb_obs_t           wb_obs,
   output logic                        st_valid,
   output pipe_pkg::st_obs_t           st_obs
);

   pipe_pkg::mem_req_t   load_req, fetch_req, data_req, mem_req;
   logic                 fetch_gnt;
   logic [`CPU_XLEN-1:0] mem_rdata;   // raw array output
   logic [`CPU_XLEN-1:0] core_rdata;  // after the arbiter

   // the loader only ever writes
   assign load_req = '{strobe: load_valid, we: 1'b1, addr: load_addr, wdata: load_data};

   pipe_core u_pipe_core (
      .clk       (clk),
      .rst       (rst),
      .mem_rdata (core_rdata),
      .fetch_gnt (fetch_gnt),
      .fetch_req (fetch_req),
      .data_req  (data_req),
      .wb_valid  (wb_valid),
      .wb_obs    (wb_obs),
      .st_valid  (st_valid),
      .st_obs    (st_obs)
   );

   mem_arbiter u_mem_arbiter (
      .load_req  (load_req),
      .data_req  (data_req),
      .fetch_req (fetch_req),
      .mem_rdata (mem_rdata),
      .mem_req   (mem_req),
      .rdata     (core_rdata),
      .fetch_gnt (fetch_gnt),
      .data_gnt  ()               // data stage never waits
   );

   unified_mem u_unified_mem (
      .clk   (clk),
      .req   (mem_req),
      .rdata (mem_rdata)
   );

endmodule

`default_nettype wire

// ==== rtl/forward_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module forward_unit (
   input  wire isa_pkg::opcode_e             id_ex_opcode,
   input  wire logic [$clog2(`CPU_REGS)-1:0] id_ex_rs1,
   input  wire logic [$clog2(`CPU_REGS)-1:0] id_ex_rs2,
   input  wire logic [$clog2(`CPU_REGS)-1:0] ex_mem_rd,
   input  wire logic [$clog2(`CPU_REGS)-1:0] mem_wb_rd,
   input  wire logic                         ex_mem_wr,
   input  wire logic                         mem_wb_wr,
   output pipe_pkg::fwd_a_e                  forward_a,
   output pipe_pkg::fwd_b_e                  forward_b,
   output pipe_pkg::fwd_st_e                 store_rs2_forward
);

   logic ex_hit_rs1, ex_hit_rs2;    // newest producer, one ahead
   logic wb_hit_rs1, wb_hit_rs2;    // older producer, two ahead
   logic use_imm;

   // r0 is never a producer
   assign ex_hit_rs1 = ex_mem_wr && (ex_mem_rd != '0) && (ex_mem_rd == id_ex_rs1);
   assign ex_hit_rs2 = ex_mem_wr && (ex_mem_rd != '0) && (ex_mem_rd == id_ex_rs2);
   assign wb_hit_rs1 = mem_wb_wr && (mem_wb_rd != '0) && (mem_wb_rd == id_ex_rs1);
   assign wb_hit_rs2 = mem_wb_wr && (mem_wb_rd != '0) && (mem_wb_rd == id_ex_rs2);

   // I-format, memory and shift ops take the immediate as operand B
   assign use_imm = id_ex_opcode inside {isa_pkg::op_addi, isa_pkg::op_andi,
                                         isa_pkg::op_ori, isa_pkg::op_xori,
                                         isa_pkg::op_slti, isa_pkg::op_sll,
                                         isa_pkg::op_srl, isa_pkg::op_lw,
                                         isa_pkg::op_sw};

   always_comb begin
      if (id_ex_opcode == isa_pkg::op_jal) forward_a = pipe_pkg::fa_pc;  // link = pc + 1
      else if (ex_hit_rs1)                 forward_a = pipe_pkg::fa_ex_mem;
      else if (wb_hit_rs1)                 forward_a = pipe_pkg::fa_mem_wb;
      else                                 forward_a = pipe_pkg::fa_reg;
   end

   always_comb begin
      if (use_imm)                              forward_b = pipe_pkg::fb_imm;
      else if (id_ex_opcode == isa_pkg::op_jal) forward_b = pipe_pkg::fb_one;
      else if (ex_hit_rs2)                      forward_b = pipe_pkg::fb_ex_mem;
      else if (wb_hit_rs2)                      forward_b = pipe_pkg::fb_mem_wb;
      else                                      forward_b = pipe_pkg::fb_reg;
   end

   // store data tracks rs2 even though operand B is the offset
   always_comb begin
      if (ex_hit_rs2)      store_rs2_forward = pipe_pkg::fs_ex_mem;
      else if (wb_hit_rs2) store_rs2_forward = pipe_pkg::fs_mem_wb;
      else                 store_rs2_forward = pipe_pkg::fs_reg;
   end

endmodule

`default_nettype wire

// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   // opcode field, low 7 bits of every instruction
   // 0x0x register-register, 0x1x immediate, 0x2x memory, 0x30 jump
   typedef enum logic [6:0] {
      op_nop  = 7'h00,  // all-zero word, no effect
      op_add  = 7'h01,
      op_sub  = 7'h02,
      op_and  = 7'h03,
      op_or   = 7'h04,
      op_xor  = 7'h05,
      op_slt  = 7'h06,  // signed compare
      op_addi = 7'h11,
      op_andi = 7'h13,
      op_ori  = 7'h14,
      op_xori = 7'h15,
      op_slti = 7'h16,
      op_sll  = 7'h17,  // shift amount from imm[4:0]
      op_srl  = 7'h18,
      op_lw   = 7'h20,  // rd <= mem[rs1 + imm]
      op_sw   = 7'h21,  // mem[rs1 + imm] <= rs2
      op_jal  = 7'h30   // rd <= pc + 1, pc <= pc + imm
   } opcode_e;

   // single instruction format, msb first
   typedef struct packed {
      logic [9:0] imm;      // signed, extended in decode
      logic [4:0] rs2;      // store data register for sw
      logic [4:0] rs1;
      logic [4:0] rd;
      opcode_e    opcode;
   } instr_t;

endpackage

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module mem_arbiter (
   input  wire pipe_pkg::mem_req_t     load_req,   // external loader, highest
   input  wire pipe_pkg::mem_req_t     data_req,   // memory stage
   input  wire pipe_pkg::mem_req_t     fetch_req,  // instruction fetch, lowest
   input  wire logic [`CPU_XLEN-1:0]   mem_rdata,
   output pipe_pkg::mem_req_t          mem_req,
   output logic [`CPU_XLEN-1:0]        rdata,      // shared by all requesters
   output logic                        fetch_gnt,
   output logic                        data_gnt
);

   // fixed priority, losers are simply dropped this cycle
   always_comb begin
      mem_req   = '0;  // idle port, no write
      fetch_gnt = 1'b0;
      data_gnt  = 1'b0;
      if (load_req.strobe) begin
         mem_req = load_req;
      end else if (data_req.strobe) begin
         mem_req  = data_req;
         data_gnt = 1'b1;
      end else if (fetch_req.strobe) begin
         mem_req   = fetch_req;
         fetch_gnt = 1'b1;
      end
   end

   // read data only means something while a request owns the port
   assign rdata = mem_req.strobe ? mem_rdata : '0;

endmodule

`default_nettype wire

// ==== rtl/pipe_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module pipe_core (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic [`CPU_XLEN-1:0] mem_rdata,
   input  wire logic                 fetch_gnt,
   output pipe_pkg::mem_req_t        fetch_req,
   output pipe_pkg::mem_req_t        data_req,
   output logic                      wb_valid,
   output pipe_pkg::wb_obs_t         wb_obs,
   output logic                      st_valid,
   output pipe_pkg::st_obs_t         st_obs
);

   // fetch/decode register, only the core needs it
   typedef struct packed {
      logic                   valid;
      logic [`CPU_ADDR_W-1:0] pc;
      isa_pkg::instr_t        instr;
   } if_id_t;

   logic                   fetch_on;  // low through reset and one cycle after
   logic [`CPU_ADDR_W-1:0] pc;
   if_id_t                 if_id;
   pipe_pkg::id_ex_t       id_ex;
   pipe_pkg::ex_mem_t      ex_mem;
   pipe_pkg::mem_wb_t      mem_wb;

   logic [`CPU_XLEN-1:0]   rs1_rf, rs2_rf, dec_imm;
   isa_pkg::instr_t        dec_instr, ex_instr;

   pipe_pkg::fwd_a_e       fwd_a;
   pipe_pkg::fwd_b_e       fwd_b;
   pipe_pkg::fwd_st_e      fwd_st;
   logic [`CPU_XLEN-1:0]   mem_result;          // ex/mem value as seen by later stages
   logic [`CPU_XLEN-1:0]   op_a, op_b, st_data, alu_out;
   logic                   ex_jal, ex_wb;
   logic [`CPU_ADDR_W-1:0] jal_target;
   logic                   mem_access, mem_store;

   // fetch, pc held and a bubble sent when the port is taken
   assign fetch_req = '{strobe: fetch_on, we: 1'b0, addr: pc, wdata: '0};

   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_on    <= 1'b0;
         pc          <= '0;
         if_id.valid <= 1'b0;
      end else begin
         fetch_on <= 1'b1;
         if (ex_jal) begin
            pc          <= jal_target;  // redirect, drop the word in flight
            if_id.valid <= 1'b0;
         end else if (fetch_gnt) begin
            pc    <= pc + 1'b1;
            if_id <= '{valid: 1'b1, pc: pc, instr: isa_pkg::instr_t'(mem_rdata)};
         end else begin
            if_id.valid <= 1'b0;
         end
      end
   end

   // decode
   assign dec_instr = if_id.instr;
   assign dec_imm   = {{(`CPU_XLEN-$bits(dec_instr.imm)){dec_instr.imm[9]}}, dec_instr.imm};

   regfile u_regfile (
      .clk      (clk),
      .rst      (rst),
      .rs1_addr (dec_instr.rs1),
      .rs2_addr (dec_instr.rs2),
      .wr_en    (mem_wb.valid && mem_wb.wb),  // r0 filtered inside
      .wr_addr  (mem_wb.rd),
      .wr_data  (mem_wb.result),
      .rs1_data (rs1_rf),
      .rs2_data (rs2_rf)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         id_ex.valid <= 1'b0;
      end else begin
         id_ex <= '{valid: if_id.valid && !ex_jal, pc: if_id.pc, instr: dec_instr,
                    rs1_val: rs1_rf, rs2_val: rs2_rf, imm: dec_imm};
      end
   end

   // execute
   assign ex_instr   = id_ex.instr;
   assign ex_jal     = id_ex.valid && (ex_instr.opcode == isa_pkg::op_jal);
   assign jal_target = id_ex.pc + id_ex.imm[`CPU_ADDR_W-1:0];
   assign ex_wb      = !(ex_instr.opcode inside {isa_pkg::op_nop, isa_pkg::op_sw});
   assign mem_result = ex_mem.mem_rd ? mem_rdata : ex_mem.result;  // load data same cycle

   forward_unit u_forward_unit (
      .id_ex_opcode      (ex_instr.opcode),
      .id_ex_rs1         (ex_instr.rs1),
      .id_ex_rs2         (ex_instr.rs2),
      .ex_mem_rd         (ex_mem.rd),
      .mem_wb_rd         (mem_wb.rd),
      .ex_mem_wr         (ex_mem.valid && ex_mem.wb),
      .mem_wb_wr         (mem_wb.valid && mem_wb.wb),
      .forward_a         (fwd_a),
      .forward_b         (fwd_b),
      .store_rs2_forward (fwd_st)
   );

   always_comb begin
      case (fwd_a)
         pipe_pkg::fa_pc:     op_a = {{(`CPU_XLEN-`CPU_ADDR_W){1'b0}}, id_ex.pc};
         pipe_pkg::fa_ex_mem: op_a = mem_result;
         pipe_pkg::fa_mem_wb: op_a = mem_wb.result;
         default:             op_a = id_ex.rs1_val;
      endcase
      case (fwd_b)
         pipe_pkg::fb_imm:    op_b = id_ex.imm;
         pipe_pkg::fb_one:    op_b = 1;
         pipe_pkg::fb_ex_mem: op_b = mem_result;
         pipe_pkg::fb_mem_wb: op_b = mem_wb.result;
         default:             op_b = id_ex.rs2_val;
      endcase
      case (fwd_st)
         pipe_pkg::fs_ex_mem: st_data = mem_result;
         pipe_pkg::fs_mem_wb: st_data = mem_wb.result;
         default:             st_data = id_ex.rs2_val;
      endcase
   end

   // alu, lw/sw/jal use the adder
   always_comb begin
      case (ex_instr.opcode)
         isa_pkg::op_sub:                  alu_out = op_a - op_b;
         isa_pkg::op_and, isa_pkg::op_andi: alu_out = op_a & op_b;
         isa_pkg::op_or, isa_pkg::op_ori:   alu_out = op_a | op_b;
         isa_pkg::op_xor, isa_pkg::op_xori: alu_out = op_a ^ op_b;
         isa_pkg::op_slt, isa_pkg::op_slti:
            alu_out = {{(`CPU_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         isa_pkg::op_sll:                  alu_out = op_a << op_b[4:0];
         isa_pkg::op_srl:                  alu_out = op_a >> op_b[4:0];
         default:                          alu_out = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_mem.valid <= 1'b0;
      end else begin
         ex_mem <= '{valid: id_ex.valid, opcode: ex_instr.opcode, rd: ex_instr.rd,
                     wb: ex_wb, mem_rd: ex_instr.opcode == isa_pkg::op_lw,
                     result: alu_out, store_data: st_data};
      end
   end

   // memory stage, always wins the port over fetch
   assign mem_store  = ex_mem.valid && (ex_mem.opcode == isa_pkg::op_sw);
   assign mem_access = ex_mem.valid && ex_mem.mem_rd || mem_store;
   assign data_req   = '{strobe: mem_access, we: mem_store,
                         addr: ex_mem.result[`CPU_ADDR_W-1:0], wdata: ex_mem.store_data};

   assign st_valid = mem_store;
   assign st_obs   = '{addr: ex_mem.result[`CPU_ADDR_W-1:0], data: ex_mem.store_data};

   always_ff @(posedge clk) begin
      if (rst) begin
         mem_wb.valid <= 1'b0;
      end else begin
         mem_wb <= '{valid: ex_mem.valid, rd: ex_mem.rd, wb: ex_mem.wb, result: mem_result};
      end
   end

   // write-back observation, r0 writes are silent
   assign wb_valid = mem_wb.valid && mem_wb.wb && (mem_wb.rd != '0);
   assign wb_obs   = '{rd: mem_wb.rd, data: mem_wb.result};

endmodule

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
`default_nettype none
`include "cpu_settings.svh"

package pipe_pkg;

   // operand A source for the ALU
   typedef enum logic [1:0] {
      fa_pc     = 2'b00,  // jal links from the pc
      fa_ex_mem = 2'b01,
      fa_mem_wb = 2'b10,
      fa_reg    = 2'b11
   } fwd_a_e;

   // operand B source
   typedef enum logic [2:0] {
      fb_imm    = 3'b000,
      fb_one    = 3'b001,  // jal adds one to the pc
      fb_ex_mem = 3'b010,
      fb_mem_wb = 3'b011,
      fb_reg    = 3'b100
   } fwd_b_e;

   // store data source
   typedef enum logic [1:0] {
      fs_reg    = 2'b00,
      fs_ex_mem = 2'b01,
      fs_mem_wb = 2'b10
   } fwd_st_e;

   // one request on the shared memory port
   typedef struct packed {
      logic                   strobe;
      logic                   we;
      logic [`CPU_ADDR_W-1:0] addr;
      logic [`CPU_XLEN-1:0]   wdata;
   } mem_req_t;

   typedef struct packed {
      logic                   valid;
      logic [`CPU_ADDR_W-1:0] pc;
      isa_pkg::instr_t        instr;
      logic [`CPU_XLEN-1:0]   rs1_val;  // register file value, may be stale
      logic [`CPU_XLEN-1:0]   rs2_val;
      logic [`CPU_XLEN-1:0]   imm;      // sign extended
   } id_ex_t;

   typedef struct packed {
      logic                        valid;
      isa_pkg::opcode_e            opcode;
      logic [$clog2(`CPU_REGS)-1:0] rd;
      logic                        wb;      // writes rd at the end
      logic                        mem_rd;  // lw, result comes from memory
      logic [`CPU_XLEN-1:0]        result;  // alu out, also the memory address
      logic [`CPU_XLEN-1:0]        store_data;
   } ex_mem_t;

   typedef struct packed {
      logic                        valid;
      logic [$clog2(`CPU_REGS)-1:0] rd;
      logic                        wb;
      logic [`CPU_XLEN-1:0]        result;
   } mem_wb_t;

   // observation records
   typedef struct packed {
      logic [$clog2(`CPU_REGS)-1:0] rd;
      logic [`CPU_XLEN-1:0]        data;
   } wb_obs_t;

   typedef struct packed {
      logic [`CPU_ADDR_W-1:0] addr;
      logic [`CPU_XLEN-1:0]   data;
   } st_obs_t;

endpackage

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module regfile (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic [$clog2(`CPU_REGS)-1:0] rs1_addr,
   input  wire logic [$clog2(`CPU_REGS)-1:0] rs2_addr,
   input  wire logic                         wr_en,
   input  wire logic [$clog2(`CPU_REGS)-1:0] wr_addr,
   input  wire logic [`CPU_XLEN-1:0]         wr_data,
   output logic [`CPU_XLEN-1:0]              rs1_data,
   output logic [`CPU_XLEN-1:0]              rs2_data
);

   logic [`CPU_XLEN-1:0] regs [1:`CPU_REGS-1];  // no storage for r0

   // r0 reads zero, a write in flight to the same register wins
   function automatic logic [`CPU_XLEN-1:0] read_port(input logic [$clog2(`CPU_REGS)-1:0] addr);
      if (addr == '0)                          return '0;
      else if (wr_en && (wr_addr == addr))     return wr_data;  // write-through
      else                                     return regs[addr];
   endfunction

   always_comb rs1_data = read_port(rs1_addr);
   always_comb rs2_data = read_port(rs2_addr);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < `CPU_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_addr != '0)) begin
         regs[wr_addr] <= wr_data;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/unified_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module unified_mem (
   input  wire logic                 clk,
   input  wire pipe_pkg::mem_req_t   req,
   output logic [`CPU_XLEN-1:0]      rdata
);

   // program and data share this array, filled by the loader
   logic [`CPU_XLEN-1:0] mem [`CPU_MEM_WORDS];

   // asynchronous read, same cycle as the request
   assign rdata = mem[req.addr];

   always_ff @(posedge clk) begin
      if (req.strobe && req.we) begin
         mem[req.addr] <= req.wdata;  // visible from the next cycle
      end
   end

endmodule

`default_nettype wire

// ==== tests/cpu_top_stim.txt ====
# P addr word : program or data word for the loader
# W rd data   : expected register write, in order;  S addr data : expected store
P 000 01400091
P 001 00C00111
P 002 00041181
P 003 00043202
P 004 00064285
P 005 00085303
P 006 00066384
P 007 000E2406
P 008 FF000491
P 009 00109506
P 00A FE009596
P 00B 01807613
P 00C 0C00C694
P 00D 3FC0D715
P 00E 0100E797
P 00F 0080F818
P 010 001D0881
P 011 0002F902
P 012 01C12011
P 013 00240981
P 014 40000A11
P 015 00413A91
P 016 00AB4021
P 017 00814B20
P 018 002D6B81
P 019 10014C20
P 01A 002F8C85
P 01B 00C00D30
P 01C 04400D91
P 01D 08800E11
P 01E 0401AE91
P 01F 00000030
P 140 0BADF00D
W 01 00000005
W 02 00000003
W 03 00000008
W 04 00000005
W 05 0000000D
W 06 00000005
W 07 0000000D
W 08 00000001
W 09 FFFFFFFC
W 0A 00000001
W 0B 00000000
W 0C 00000004
W 0D 00000034
W 0E 000000CB
W 0F 00000CB0
W 10 0000032C
W 11 000003F7
W 12 00000CAB
W 13 00000CAB
W 14 00000100
W 15 00000CAC
W 16 00000CAC
W 17 00001958
W 18 0BADF00D
W 19 0BADE955
W 1A 0000001C
W 1D 0000002C
S 102 00000CAC

// ==== tests/tb_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module tb_cpu_top;

   logic                   clk;
   logic                   rst;
   logic                   load_valid;
   logic [`CPU_ADDR_W-1:0] load_addr;
   logic [`CPU_XLEN-1:0]   load_data;
   logic                   wb_valid;
   logic                   st_valid;
   pipe_pkg::wb_obs_t      wb_obs;
   pipe_pkg::st_obs_t      st_obs;

   logic [`CPU_ADDR_W-1:0] prog_addr[$];  // loader image
   logic [`CPU_XLEN-1:0]   prog_word[$];
   pipe_pkg::wb_obs_t      exp_wb[$], got_wb[$];
   pipe_pkg::st_obs_t      exp_st[$], got_st[$];
   int                     checks = 0;
   int                     errors = 0;

   cpu_top DUT (
      .clk        (clk),
      .rst        (rst),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .wb_valid   (wb_valid),
      .wb_obs     (wb_obs),
      .st_valid   (st_valid),
      .st_obs     (st_obs)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;  // 100 ns period

   // outputs settle well before the falling edge
   always @(negedge clk) begin
      if (!rst && wb_valid) got_wb.push_back(wb_obs);
      if (!rst && st_valid) got_st.push_back(st_obs);
   end

   // one record per line as a kind letter and two hex fields
   task automatic read_stim(output bit ok);
      int                fd;
      int                n;
      string             line;
      logic [7:0]        kind;
      logic [31:0]       a, b;
      pipe_pkg::wb_obs_t w;
      pipe_pkg::st_obs_t s;
      ok = 1'b0;
      fd = $fopen("tests/cpu_top_stim.txt", "r");
      if (fd == 0) return;
      while ($fgets(line, fd) > 0) begin
         n = 0;
         if (line.len() > 1 && line[0] != "#") begin  // skip blank and comment lines
            n = $sscanf(line, "%c %h %h", kind, a, b);
         end
         if (n == 3 && kind == "P") begin
            prog_addr.push_back(a[`CPU_ADDR_W-1:0]);
            prog_word.push_back(b);
         end else if (n == 3 && kind == "W") begin
            w.rd   = a[$clog2(`CPU_REGS)-1:0];
            w.data = b;
            exp_wb.push_back(w);
         end else if (n == 3 && kind == "S") begin
            s.addr = a[`CPU_ADDR_W-1:0];
            s.data = b;
            exp_st.push_back(s);
         end
      end
      $fclose(fd);
      ok = 1'b1;
   endtask

   task automatic check_wb(input pipe_pkg::wb_obs_t got, input pipe_pkg::wb_obs_t exp,
                           input int idx);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] wb_obs #%0d got rd=%h data=%h, expected rd=%h data=%h",
                  idx, got.rd, got.data, exp.rd, exp.data);
      end else begin
         $display("[PASS] wb_obs #%0d rd=%h data=%h", idx, got.rd, got.data);
      end
   endtask

   task automatic check_st(input pipe_pkg::st_obs_t got, input pipe_pkg::st_obs_t exp,
                           input int idx);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] st_obs #%0d got addr=%h data=%h, expected addr=%h data=%h",
                  idx, got.addr, got.data, exp.addr, exp.data);
      end else begin
         $display("[PASS] st_obs #%0d addr=%h data=%h", idx, got.addr, got.data);
      end
   endtask

   // true while some expected record has not shown up yet
   function automatic bit records_missing();
      return (got_wb.size() < exp_wb.size()) || (got_st.size() < exp_st.size());
   endfunction

   // bounded wait for every expected write-back and store
   task automatic wait_for_records();
      int cycles;
      cycles = 0;
      while (records_missing() && cycles < 200) begin
         @(posedge clk);
         cycles++;
      end
      if (records_missing()) begin
         errors++;
         $display("timeout: saw %0d of %0d register writes and %0d of %0d stores",
                  got_wb.size(), exp_wb.size(), got_st.size(), exp_st.size());
      end
   endtask

   initial begin
      bit ok;
      rst        = 1'b1;
      load_valid = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      read_stim(ok);
      if (!ok) begin
         errors++;
         $display("could not open the stimulus file tests/cpu_top_stim.txt");
      end
      repeat (3) @(posedge clk);
      // program goes in while the core is held in reset
      for (int i = 0; i < prog_addr.size(); i++) begin
         @(posedge clk);
         load_valid <= 1'b1;
         load_addr  <= prog_addr[i];
         load_data  <= prog_word[i];
      end
      @(posedge clk);
      load_valid <= 1'b0;  // last word written on this edge
      @(posedge clk);
      rst <= 1'b0;
      wait_for_records();
      repeat (20) @(posedge clk);  // the self loop must stay silent
      if (got_wb.size() > exp_wb.size() || got_st.size() > exp_st.size()) begin
         errors++;
         $display("unexpected extra activity: %0d register writes and %0d stores seen",
                  got_wb.size(), got_st.size());
      end
      for (int i = 0; i < exp_wb.size() && i < got_wb.size(); i++) begin
         check_wb(got_wb[i], exp_wb[i], i);
      end
      for (int i = 0; i < exp_st.size() && i < got_st.size(); i++) begin
         check_st(got_st[i], exp_st[i], i);
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
